// ==== verilog/raster_pkg.sv ====
package raster_pkg;

    // ==============================
    // screen and number format
    // ==============================
    localparam int screen_w  = 320;
    localparam int screen_h  = 240;
    localparam int frac_bits = 16;

    typedef logic signed [31:0] coord_t;
    typedef logic [8:0]         pix_t;
    typedef logic [23:0]        color_t;
    typedef logic signed [31:0] depth_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
        color_t color;
    } vertex_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef struct packed {
        pix_t min_x;
        pix_t max_x;
        pix_t min_y;
        pix_t max_y;
    } bbox_t;

    // provoking vertex attributes, flat shading
    typedef struct packed {
        color_t color;
        depth_t depth;
    } attr_t;

    typedef struct packed {
        pix_t   x;
        pix_t   y;
        color_t color;
        depth_t depth;
    } frag_t;

    // ==============================
    // helpers for bounding boxes
    // ==============================
    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // whole-pixel value into 0 .. lim
    function automatic pix_t clamp_pix(coord_t v, coord_t lim);
        if (v < 0)
            return '0;
        if (v > lim)
            return lim[8:0];
        return v[8:0];
    endfunction

endpackage

// ==== verilog/tri_if.sv ====
`timescale 1ns/1ps

interface tri_if;

    // triangle corners in screen space
    raster_pkg::point_t p0;
    raster_pkg::point_t p1;
    raster_pkg::point_t p2;

    raster_pkg::bbox_t  box;
    raster_pkg::attr_t  attr;

    logic valid;
    logic ready;

    modport producer (
        output p0, p1, p2, box, attr, valid,
        input  ready
    );

    modport consumer (
        input  p0, p1, p2, box, attr, valid,
        output ready
    );

endinterface

// ==== verilog/triangle_setup.sv ====
`timescale 1ns/1ps

module triangle_setup (
    input  logic                clk,
    input  logic                rst,
    input  raster_pkg::vertex_t v0,
    input  raster_pkg::vertex_t v1,
    input  raster_pkg::vertex_t v2,
    input  logic                in_valid,
    output logic                in_ready,
    tri_if.producer             out
);

    raster_pkg::coord_t lo_x;
    raster_pkg::coord_t hi_x;
    raster_pkg::coord_t lo_y;
    raster_pkg::coord_t hi_y;
    logic               take;

    // one entry output register
    assign in_ready = !out.valid || out.ready;
    assign take     = in_valid && in_ready;

    // floor of the minimum, ceiling of the maximum
    always_comb begin
        lo_x = raster_pkg::min3(v0.x, v1.x, v2.x) >>> raster_pkg::frac_bits;
        lo_y = raster_pkg::min3(v0.y, v1.y, v2.y) >>> raster_pkg::frac_bits;
        hi_x = (raster_pkg::max3(v0.x, v1.x, v2.x) + 32'sd65535) >>> raster_pkg::frac_bits;
        hi_y = (raster_pkg::max3(v0.y, v1.y, v2.y) + 32'sd65535) >>> raster_pkg::frac_bits;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (take) begin
            out.valid <= 1'b1;
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out.p0 <= '{x: v0.x, y: v0.y};
            out.p1 <= '{x: v1.x, y: v1.y};
            out.p2 <= '{x: v2.x, y: v2.y};

            out.box.min_x <= raster_pkg::clamp_pix(lo_x, raster_pkg::screen_w - 1);
            out.box.max_x <= raster_pkg::clamp_pix(hi_x, raster_pkg::screen_w - 1);
            out.box.min_y <= raster_pkg::clamp_pix(lo_y, raster_pkg::screen_h - 1);
            out.box.max_y <= raster_pkg::clamp_pix(hi_y, raster_pkg::screen_h - 1);

            // flat shading, v0 provokes
            out.attr.color <= v0.color;
            out.attr.depth <= v0.z;
        end
    end

endmodule

// ==== verilog/tri_fifo.sv ====
`timescale 1ns/1ps

module tri_fifo #(
    parameter int depth = 4
) (
    input  logic    clk,
    input  logic    rst,
    tri_if.consumer in,
    tri_if.producer out
);

    // one storage word holds every triangle field
    logic [3*$bits(raster_pkg::point_t) + $bits(raster_pkg::bbox_t)
           + $bits(raster_pkg::attr_t) - 1:0] mem [depth];

    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth):0]   count;
    logic                     do_wr;
    logic                     do_rd;

    assign in.ready  = count != ($clog2(depth) + 1)'(depth);
    assign out.valid = count != '0;

    assign do_wr = in.valid && in.ready;
    assign do_rd = out.valid && out.ready;

    // head of the queue goes straight out
    assign {out.p0, out.p1, out.p2, out.box, out.attr} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= {in.p0, in.p1, in.p2, in.box, in.attr};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/coverage_walker.sv ====
`timescale 1ns/1ps

module coverage_walker (
    input  logic              clk,
    input  logic              rst,
    tri_if.consumer           in,
    output raster_pkg::frag_t frag,
    output logic              frag_valid,
    input  logic              frag_ready,
    output logic              tri_done,
    output logic              active
);

    enum logic [1:0] {st_idle, st_scan, st_drain} state;

    // current triangle
    raster_pkg::point_t p0_r;
    raster_pkg::point_t p1_r;
    raster_pkg::point_t p2_r;
    raster_pkg::bbox_t  box_r;
    raster_pkg::attr_t  attr_r;

    raster_pkg::pix_t   cur_x;
    raster_pkg::pix_t   cur_y;
    raster_pkg::coord_t px;
    raster_pkg::coord_t py;
    logic signed [63:0] e0;
    logic signed [63:0] e1;
    logic signed [63:0] e2;
    logic               covered;
    logic               step;
    logic               load;

    function automatic logic signed [63:0] edge_fn(raster_pkg::point_t a,
                                                   raster_pkg::point_t b,
                                                   raster_pkg::coord_t x,
                                                   raster_pkg::coord_t y);
        logic signed [63:0] dx;
        logic signed [63:0] dy;
        dx = 64'(b.x) - 64'(a.x);
        dy = 64'(b.y) - 64'(a.y);
        return dx * (64'(y) - 64'(a.y)) - dy * (64'(x) - 64'(a.x));
    endfunction

    // ==============================
    // edge test at the pixel centre
    // ==============================
    assign px = raster_pkg::coord_t'({7'd0, cur_x, 16'h8000});
    assign py = raster_pkg::coord_t'({7'd0, cur_y, 16'h8000});

    assign e0 = edge_fn(p0_r, p1_r, px, py);
    assign e1 = edge_fn(p1_r, p2_r, px, py);
    assign e2 = edge_fn(p2_r, p0_r, px, py);

    // either winding counts
    assign covered = (e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0);

    assign step = state == st_scan && (!frag_valid || frag_ready);
    assign load = step && covered;

    assign in.ready = state == st_idle;
    assign tri_done = state == st_drain && !frag_valid;
    assign active   = state != st_idle;

    // ==============================
    // scan control
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            cur_x      <= '0;
            cur_y      <= '0;
            frag_valid <= 1'b0;
        end else begin
            if (load)
                frag_valid <= 1'b1;
            else if (frag_ready)
                frag_valid <= 1'b0;

            case (state)
                st_idle: begin
                    if (in.valid) begin
                        cur_x <= in.box.min_x;
                        cur_y <= in.box.min_y;
                        state <= st_scan;
                    end
                end
                st_scan: begin
                    if (step) begin
                        if (cur_x == box_r.max_x) begin
                            cur_x <= box_r.min_x;
                            if (cur_y == box_r.max_y)
                                state <= st_drain;
                            else
                                cur_y <= cur_y + 1'b1;
                        end else begin
                            cur_x <= cur_x + 1'b1;
                        end
                    end
                end
                default: begin
                    // wait for the last fragment to leave
                    if (!frag_valid)
                        state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            p0_r   <= in.p0;
            p1_r   <= in.p1;
            p2_r   <= in.p2;
            box_r  <= in.box;
            attr_r <= in.attr;
        end
        if (load) begin
            frag.x     <= cur_x;
            frag.y     <= cur_y;
            frag.color <= attr_r.color;
            frag.depth <= attr_r.depth;
        end
    end

endmodule

// ==== verilog/raster_front.sv ====
`timescale 1ns/1ps

module raster_front (
    input  logic                clk,
    input  logic                rst,
    input  raster_pkg::vertex_t v0,
    input  raster_pkg::vertex_t v1,
    input  raster_pkg::vertex_t v2,
    input  logic                in_valid,
    output logic                in_ready,
    output raster_pkg::frag_t   frag,
    output logic                frag_valid,
    input  logic                frag_ready,
    output logic                tri_done,
    output logic                busy
);

    logic walker_active;

    tri_if setup_to_fifo ();
    tri_if fifo_to_walker ();

    triangle_setup setup (
        .clk      (clk),
        .rst      (rst),
        .v0       (v0),
        .v1       (v1),
        .v2       (v2),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out      (setup_to_fifo.producer)
    );

    tri_fifo #(
        .depth (4)
    ) fifo (
        .clk (clk),
        .rst (rst),
        .in  (setup_to_fifo.consumer),
        .out (fifo_to_walker.producer)
    );

    coverage_walker walker (
        .clk        (clk),
        .rst        (rst),
        .in         (fifo_to_walker.consumer),
        .frag       (frag),
        .frag_valid (frag_valid),
        .frag_ready (frag_ready),
        .tri_done   (tri_done),
        .active     (walker_active)
    );

    // any stage holding a triangle
    assign busy = setup_to_fifo.valid || fifo_to_walker.valid || walker_active;

endmodule

// ==== bench/raster_model.svh ====
// ==============================
// random numbers
// ==============================

// 32 bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken
function automatic logic [31:0] draw_bits(inout logic [31:0] state, input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
        state = lfsr_step(state);
        r     = {r[30:0], state[0]};
    end
    return r;
endfunction

// ==============================
// reference bounding box
// ==============================
function automatic int min_of3(int a, int b, int c);
    int m;
    m = a;
    if (b < m)
        m = b;
    if (c < m)
        m = c;
    return m;
endfunction

function automatic int max_of3(int a, int b, int c);
    int m;
    m = a;
    if (b > m)
        m = b;
    if (c > m)
        m = c;
    return m;
endfunction

function automatic int clamp_to(int v, int hi);
    if (v < 0)
        return 0;
    if (v > hi)
        return hi;
    return v;
endfunction

// ==============================
// reference coverage
// ==============================
function automatic longint edge_value(int ax, int ay, int bx, int by, int px, int py);
    longint dx;
    longint dy;
    dx = longint'(bx) - longint'(ax);
    dy = longint'(by) - longint'(ay);
    return dx * (longint'(py) - longint'(ay)) - dy * (longint'(px) - longint'(ax));
endfunction

// pixel centre inside or on the edges, either winding
function automatic logic pixel_covered(raster_pkg::vertex_t a, raster_pkg::vertex_t b,
                                       raster_pkg::vertex_t c, int x, int y);
    int     px;
    int     py;
    longint e0;
    longint e1;
    longint e2;
    px = x * 65536 + 32768;
    py = y * 65536 + 32768;
    e0 = edge_value(a.x, a.y, b.x, b.y, px, py);
    e1 = edge_value(b.x, b.y, c.x, c.y, px, py);
    e2 = edge_value(c.x, c.y, a.x, a.y, px, py);
    return (e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0);
endfunction

// ==== bench/tb_raster_front.sv ====
`timescale 1ns/1ps

module tb_raster_front;

    logic                clk;
    logic                rst;
    raster_pkg::vertex_t v0;
    raster_pkg::vertex_t v1;
    raster_pkg::vertex_t v2;
    logic                in_valid;
    logic                in_ready;
    raster_pkg::frag_t   frag;
    logic                frag_valid;
    logic                frag_ready;
    logic                tri_done;
    logic                busy;

    // top bit set marks a tri_done in the expected stream
    logic [74:0] exp_q[$];
    logic [31:0] stim_lfsr;
    logic [31:0] bp_lfsr;
    logic        bp_on;
    logic        saw_stall;
    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;

    `include "raster_model.svh"

    raster_front UUT (
        .clk        (clk),
        .rst        (rst),
        .v0         (v0),
        .v1         (v1),
        .v2         (v2),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .frag       (frag),
        .frag_valid (frag_valid),
        .frag_ready (frag_ready),
        .tri_done   (tri_done),
        .busy       (busy)
    );

    always #20 clk = ~clk;

    // random stalls on the fragment side
    always @(negedge clk) begin
        if (bp_on)
            frag_ready = draw_bits(bp_lfsr, 1) != 0;
        else
            frag_ready = 1'b1;
    end

    // ==============================
    // output checking
    // ==============================
    task automatic check_fragment();
        logic [74:0] head;
        if (exp_q.size() == 0) begin
            $display("%s: fragment %h arrived with none expected", test_name, frag);
            test_errors++;
        end else begin
            head = exp_q.pop_front();
            if (head !== {1'b0, frag}) begin
                $display("FAILED %s: expected %h, actual %h", test_name, head, {1'b0, frag});
                test_errors++;
            end
        end
    endtask

    task automatic check_done();
        logic [74:0] head;
        if (exp_q.size() == 0) begin
            $display("%s: tri_done pulsed with no triangle outstanding", test_name);
            test_errors++;
        end else begin
            head = exp_q.pop_front();
            if (!head[74]) begin
                $display("%s: tri_done pulsed while fragment %h was still expected",
                         test_name, head);
                test_errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && frag_valid && frag_ready)
            check_fragment();
        if (!rst && tri_done)
            check_done();
    end

    task automatic check_idle();
        if (frag_valid !== 1'b0) begin
            $display("FAILED %s: frag_valid expected 0, actual %b", test_name, frag_valid);
            test_errors++;
        end
        if (tri_done !== 1'b0) begin
            $display("FAILED %s: tri_done expected 0, actual %b", test_name, tri_done);
            test_errors++;
        end
        if (busy !== 1'b0) begin
            $display("FAILED %s: busy expected 0, actual %b", test_name, busy);
            test_errors++;
        end
    endtask

    // ==============================
    // stimulus and model
    // ==============================
    function automatic raster_pkg::vertex_t vertex_at(int fx, int fy);
        raster_pkg::vertex_t v;
        v.x     = fx;
        v.y     = fy;
        v.z     = draw_bits(stim_lfsr, 32);
        v.color = 24'(draw_bits(stim_lfsr, 24));
        return v;
    endfunction

    // whole pixel offset 0 .. span from (bx, by) plus a random fraction
    function automatic raster_pkg::vertex_t random_vertex(int bx, int by, int span);
        int fx;
        int fy;
        fx = (bx + int'(draw_bits(stim_lfsr, 8)) % (span + 1)) * 65536;
        fx = fx + int'(draw_bits(stim_lfsr, 16));
        fy = (by + int'(draw_bits(stim_lfsr, 8)) % (span + 1)) * 65536;
        fy = fy + int'(draw_bits(stim_lfsr, 16));
        return vertex_at(fx, fy);
    endfunction

    function automatic int centre(int p);
        return p * 65536 + 32768;
    endfunction

    task automatic expect_triangle(raster_pkg::vertex_t a, raster_pkg::vertex_t b,
                                   raster_pkg::vertex_t c);
        int                lo_x;
        int                hi_x;
        int                lo_y;
        int                hi_y;
        int                x;
        int                y;
        raster_pkg::frag_t f;
        lo_x = clamp_to(min_of3(a.x, b.x, c.x) >>> 16, raster_pkg::screen_w - 1);
        hi_x = clamp_to((max_of3(a.x, b.x, c.x) + 65535) >>> 16, raster_pkg::screen_w - 1);
        lo_y = clamp_to(min_of3(a.y, b.y, c.y) >>> 16, raster_pkg::screen_h - 1);
        hi_y = clamp_to((max_of3(a.y, b.y, c.y) + 65535) >>> 16, raster_pkg::screen_h - 1);
        for (y = lo_y; y <= hi_y; y++) begin
            for (x = lo_x; x <= hi_x; x++) begin
                if (pixel_covered(a, b, c, x, y)) begin
                    f.x     = 9'(x);
                    f.y     = 9'(y);
                    f.color = a.color;
                    f.depth = a.z;
                    exp_q.push_back({1'b0, f});
                end
            end
        end
        exp_q.push_back({1'b1, 74'd0});
    endtask

    task automatic stop_on_timeout(string what);
        $display("timeout: %s during %s", what, test_name);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic send_tri(raster_pkg::vertex_t a, raster_pkg::vertex_t b,
                            raster_pkg::vertex_t c);
        int waited;
        @(negedge clk);
        v0       = a;
        v1       = b;
        v2       = c;
        in_valid = 1'b1;
        waited   = 0;
        while (!in_ready) begin
            saw_stall = 1'b1;
            @(negedge clk);
            waited++;
            if (waited > 10000)
                stop_on_timeout("in_ready stayed low");
        end
        // taken at the next rising edge
        expect_triangle(a, b, c);
    endtask

    // every expected item seen, busy high while any is outstanding
    task automatic drain();
        int   waited;
        logic busy_dropped;
        @(negedge clk);
        in_valid     = 1'b0;
        waited       = 0;
        busy_dropped = 1'b0;
        while (exp_q.size() != 0) begin
            if (!busy)
                busy_dropped = 1'b1;
            @(negedge clk);
            waited++;
            if (waited > 50000)
                stop_on_timeout("the DUT did not finish its triangles");
        end
        if (busy_dropped) begin
            $display("%s: busy was low while triangles were still in flight", test_name);
            test_errors++;
        end
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("%s: passed", test_name);
            tests_passed++;
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        int                  i;
        int                  bx;
        int                  by;
        int                  idle_errors;
        raster_pkg::vertex_t a;
        raster_pkg::vertex_t b;
        raster_pkg::vertex_t c;

        clk          = 1'b0;
        rst          = 1'b1;
        v0           = '0;
        v1           = '0;
        v2           = '0;
        in_valid     = 1'b0;
        frag_ready   = 1'b1;
        stim_lfsr    = 32'hb8a6;
        bp_lfsr      = 32'hb8a6;
        bp_on        = 1'b0;
        saw_stall    = 1'b0;
        test_name    = "reset";
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_idle");
        check_idle();
        idle_errors = test_errors;

        start_test("basic_cover");
        for (i = 0; i < 10; i++) begin
            bx = int'(draw_bits(stim_lfsr, 9)) % 314;
            by = int'(draw_bits(stim_lfsr, 8)) % 234;
            a  = random_vertex(bx, by, 5);
            b  = random_vertex(bx, by, 5);
            c  = random_vertex(bx, by, 5);
            send_tri(a, b, c);
        end
        drain();
        finish_test();

        // vertices up to 8 pixels past the screen corners
        start_test("clamp_box");
        for (i = 0; i < 8; i++) begin
            bx = (i % 2 == 0) ? -8 : raster_pkg::screen_w - 9;
            by = ((i / 2) % 2 == 0) ? -8 : raster_pkg::screen_h - 9;
            a  = random_vertex(bx, by, 16);
            b  = random_vertex(bx, by, 16);
            c  = random_vertex(bx, by, 16);
            send_tri(a, b, c);
        end
        drain();
        finish_test();

        start_test("winding");
        for (i = 0; i < 5; i++) begin
            bx = int'(draw_bits(stim_lfsr, 9)) % 314;
            by = int'(draw_bits(stim_lfsr, 8)) % 234;
            a  = random_vertex(bx, by, 5);
            b  = random_vertex(bx, by, 5);
            c  = random_vertex(bx, by, 5);
            send_tri(a, b, c);
            send_tri(a, c, b);
        end
        drain();
        finish_test();

        start_test("degenerate");
        for (i = 0; i < 3; i++) begin
            bx = int'(draw_bits(stim_lfsr, 9)) % 300;
            by = int'(draw_bits(stim_lfsr, 8)) % 220;
            // row through pixel centres
            a  = vertex_at(centre(bx), centre(by));
            b  = vertex_at(centre(bx + 2), centre(by));
            c  = vertex_at(centre(bx + 4), centre(by));
            send_tri(a, b, c);
            // diagonal through pixel centres
            a  = vertex_at(centre(bx), centre(by));
            b  = vertex_at(centre(bx + 1), centre(by + 1));
            c  = vertex_at(centre(bx + 3), centre(by + 3));
            send_tri(a, b, c);
            // single point where every edge value is zero
            a  = vertex_at(centre(bx), centre(by));
            send_tri(a, a, a);
            // line between pixel rows gives no fragments
            a  = vertex_at(bx * 65536, by * 65536);
            b  = vertex_at((bx + 2) * 65536, by * 65536);
            c  = vertex_at((bx + 5) * 65536, by * 65536);
            send_tri(a, b, c);
        end
        drain();
        finish_test();

        start_test("backpressure");
        bp_on     = 1'b1;
        saw_stall = 1'b0;
        for (i = 0; i < 12; i++) begin
            bx = int'(draw_bits(stim_lfsr, 9)) % 314;
            by = int'(draw_bits(stim_lfsr, 8)) % 234;
            a  = random_vertex(bx, by, 5);
            b  = random_vertex(bx, by, 5);
            c  = random_vertex(bx, by, 5);
            send_tri(a, b, c);
        end
        drain();
        bp_on = 1'b0;
        if (!saw_stall) begin
            $display("%s: in_ready never fell while the walker was stalled", test_name);
            test_errors++;
        end
        finish_test();

        start_test("reset_idle");
        test_errors = idle_errors;
        check_idle();
        finish_test();

        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+bench
verilog/raster_pkg.sv
verilog/tri_if.sv
verilog/triangle_setup.sv
verilog/tri_fifo.sv
verilog/coverage_walker.sv
verilog/raster_front.sv
bench/tb_raster_front.sv

// ==== run.sh ====
#!/bin/sh
# build and run the raster front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_raster_front -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_raster_front)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
    exit 0
fi
exit 1
